// File: design/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
	input  logic                            CLK,
	input  logic                            rst_n,
	input  logic                            sw_load,
	input  logic                            sw_run,
	input  logic [7:0]                      rx_data,
	input  logic                            rx_req,
	output logic                            rx_ack,
	output logic [7:0]                      tx_data,
	output logic                            tx_req,
	input  logic                            tx_ack,
	output logic [cpu_pkg::DATA_ADDR_W-1:0] ram_addr,
	output logic [31:0]                     ram_wdata,
	output logic                            ram_we,
	input  logic [31:0]                     ram_rdata,
	output logic                            led_load,
	output logic                            led_run,
	output logic [5:0]                      debug_pc
);
	import cpu_pkg::*;

	mode_e                  mode;
	logic [31:0]            inst_mem [2**INST_ADDR_W];
	logic [31:0]            gpr [32];
	logic [INST_ADDR_W-1:0] pc;
	logic [INST_ADDR_W-1:0] pc_plus_1;
	logic [INST_ADDR_W-1:0] pc_next;
	logic [1:0]             byte_cnt;
	logic                   lw_stage;
	logic                   exec_mode;

	logic [31:0]            inst;
	opcode_e                op;
	funct_e                 fn;
	logic [4:0]             rs;
	logic [4:0]             rt;
	logic [4:0]             rd;
	logic [4:0]             shamt;
	logic [15:0]            imm;
	logic [31:0]            imm_sext;
	logic [31:0]            imm_zext;
	logic [31:0]            rs_val;
	logic [31:0]            rt_val;
	logic [31:0]            addr_sum;

	logic                   rx_take;
	logic                   advance;
	logic                   wb_en;
	logic [4:0]             wb_addr;
	logic [31:0]            wb_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fetch and field decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign exec_mode = mode == MODE_EXEC;
	assign inst      = inst_mem[pc];
	assign op        = opcode_e'(inst[31:26]);
	assign fn        = funct_e'(inst[5:0]);
	assign rs        = inst[25:21];
	assign rt        = inst[20:16];
	assign rd        = inst[15:11];
	assign shamt     = inst[10:6];
	assign imm       = inst[15:0];
	assign imm_sext  = {{16{imm[15]}}, imm};
	assign imm_zext  = {16'b0, imm};
	assign rs_val    = gpr[rs];
	assign rt_val    = gpr[rt];
	assign pc_plus_1 = pc + 1'b1;
	assign addr_sum  = rs_val + imm_sext;

	assign ram_addr  = addr_sum[DATA_ADDR_W-1:0];
	assign ram_wdata = rt_val;
	assign ram_we    = exec_mode && op == OP_SW;

	assign led_load  = mode == MODE_LOAD;
	assign led_run   = exec_mode;
	assign debug_pc  = {pc[3:0], byte_cnt};

	// Load mode takes every byte, exec mode only on in.
	assign rx_take = rx_req && !rx_ack && (!exec_mode || op == OP_IN);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execute: writeback, next pc, stalls
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		wb_en   = 1'b0;
		wb_addr = rt;
		wb_data = 32'b0;
		pc_next = pc_plus_1;
		advance = 1'b1;
		case (op)
			OP_SPECIAL: begin
				wb_en   = 1'b1;
				wb_addr = rd;
				case (fn)
					FUNCT_ADD: wb_data = rs_val + rt_val;
					FUNCT_SUB: wb_data = rs_val - rt_val;
					FUNCT_AND: wb_data = rs_val & rt_val;
					FUNCT_OR:  wb_data = rs_val | rt_val;
					FUNCT_NOR: wb_data = ~(rs_val | rt_val);
					FUNCT_SLL: wb_data = rt_val << shamt;
					FUNCT_SRL: wb_data = rt_val >> shamt;
					FUNCT_SLT: wb_data = {31'b0, $signed(rs_val) < $signed(rt_val)};
					FUNCT_JR: begin
						wb_en   = 1'b0;
						pc_next = rs_val[INST_ADDR_W-1:0];
					end
					FUNCT_JALR: begin
						wb_addr = 5'd31;
						wb_data = 32'(pc_plus_1);
						pc_next = rs_val[INST_ADDR_W-1:0];
					end
					default: wb_en = 1'b0;
				endcase
			end
			OP_ADDI: begin
				wb_en   = 1'b1;
				wb_data = rs_val + imm_sext;
			end
			OP_ANDI: begin
				wb_en   = 1'b1;
				wb_data = rs_val & imm_zext;
			end
			OP_ORI: begin
				wb_en   = 1'b1;
				wb_data = rs_val | imm_zext;
			end
			OP_SLTI: begin
				wb_en   = 1'b1;
				wb_data = {31'b0, $signed(rs_val) < $signed(imm_sext)};
			end
			OP_LUI: begin
				wb_en   = 1'b1;
				wb_data = {imm, 16'b0};
			end
			OP_BEQ: if (rs_val == rt_val) pc_next = pc + imm[INST_ADDR_W-1:0];
			OP_BNE: if (rs_val != rt_val) pc_next = pc + imm[INST_ADDR_W-1:0];
			OP_J:   pc_next = inst[INST_ADDR_W-1:0];
			OP_JAL: begin
				wb_en   = 1'b1;
				wb_addr = 5'd31;
				wb_data = 32'(pc_plus_1);
				pc_next = inst[INST_ADDR_W-1:0];
			end
			OP_LW: begin
				wb_en   = lw_stage;  // RAM data valid in the second cycle.
				wb_data = ram_rdata;
				advance = lw_stage;
			end
			OP_IN: begin
				wb_en   = rx_take;
				wb_data = {rt_val[31:8], rx_data};
				advance = rx_take;
			end
			OP_OUT: advance = tx_req && tx_ack;
			default: ;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			mode     <= MODE_LOAD;
			pc       <= '0;
			byte_cnt <= '0;
			lw_stage <= 1'b0;
			rx_ack   <= 1'b0;
			tx_req   <= 1'b0;
		end else begin
			if (rx_take) rx_ack <= 1'b1;
			else if (!rx_req) rx_ack <= 1'b0;
			if (sw_load) begin
				mode     <= MODE_LOAD;
				pc       <= '0;
				byte_cnt <= '0;
				lw_stage <= 1'b0;
				tx_req   <= 1'b0;
			end else if (!exec_mode) begin
				if (sw_run) begin
					mode <= MODE_EXEC;
					pc   <= '0;
				end else if (rx_take) begin
					{pc, byte_cnt} <= {pc, byte_cnt} + 1'b1;  // Next byte lane.
				end
			end else begin
				if (advance) pc <= pc_next;
				lw_stage <= op == OP_LW && !lw_stage;
				if (op == OP_OUT) begin
					if (!tx_req && !tx_ack) tx_req <= 1'b1;
					else if (tx_req && tx_ack) tx_req <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!exec_mode && rx_take) inst_mem[pc][{byte_cnt, 3'b000} +: 8] <= rx_data;
		if (exec_mode && wb_en) gpr[wb_addr] <= wb_data;
		if (exec_mode && op == OP_OUT && !tx_req) tx_data <= rt_val[7:0];
	end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths and UART timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int INST_ADDR_W  = 8;  // 256 instruction words.
	localparam int DATA_ADDR_W  = 8;  // 256 data words.
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_ADDI    = 6'b001000,
		OP_SLTI    = 6'b001010,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_LUI     = 6'b001111,
		OP_IN      = 6'b011010,  // Byte from the UART into rt[7:0].
		OP_OUT     = 6'b011011,  // Byte rt[7:0] to the UART.
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FUNCT_SLL  = 6'b000000,
		FUNCT_SRL  = 6'b000010,
		FUNCT_JR   = 6'b001000,
		FUNCT_JALR = 6'b001001,
		FUNCT_ADD  = 6'b100000,
		FUNCT_SUB  = 6'b100010,
		FUNCT_AND  = 6'b100100,
		FUNCT_OR   = 6'b100101,
		FUNCT_NOR  = 6'b100111,
		FUNCT_SLT  = 6'b101010
	} funct_e;

	typedef enum logic {
		MODE_LOAD,
		MODE_EXEC
	} mode_e;

endpackage

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input  logic       CLK,
	input  logic       rst_n,
	input  logic       uart_rx_pin,
	output logic       uart_tx_pin,
	input  logic       sw_load,
	input  logic       sw_run,
	output logic       led_load,
	output logic       led_run,
	output logic [5:0] debug_pc
);
	import cpu_pkg::*;

	logic [7:0]             rx_data;
	logic                   rx_req;
	logic                   rx_ack;
	logic [7:0]             tx_data;
	logic                   tx_req;
	logic                   tx_ack;
	logic [DATA_ADDR_W-1:0] ram_addr;
	logic [31:0]            ram_wdata;
	logic                   ram_we;
	logic [31:0]            ram_rdata;

	cpu_core core_i (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.sw_load  (sw_load),
		.sw_run   (sw_run),
		.rx_data  (rx_data),
		.rx_req   (rx_req),
		.rx_ack   (rx_ack),
		.tx_data  (tx_data),
		.tx_req   (tx_req),
		.tx_ack   (tx_ack),
		.ram_addr (ram_addr),
		.ram_wdata(ram_wdata),
		.ram_we   (ram_we),
		.ram_rdata(ram_rdata),
		.led_load (led_load),
		.led_run  (led_run),
		.debug_pc (debug_pc)
	);

	data_ram ram_i (
		.CLK      (CLK),
		.ram_addr (ram_addr),
		.ram_wdata(ram_wdata),
		.ram_we   (ram_we),
		.ram_rdata(ram_rdata)
	);

	uart_rx rx_i (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.uart_rx_pin(uart_rx_pin),
		.rx_data    (rx_data),
		.rx_req     (rx_req),
		.rx_ack     (rx_ack)
	);

	uart_tx tx_i (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.tx_data    (tx_data),
		.tx_req     (tx_req),
		.tx_ack     (tx_ack),
		.uart_tx_pin(uart_tx_pin)
	);

endmodule

`default_nettype wire

// File: design/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram (
	input  logic                         CLK,
	input  logic [cpu_pkg::DATA_ADDR_W-1:0] ram_addr,
	input  logic [31:0]                  ram_wdata,
	input  logic                         ram_we,
	output logic [31:0]                  ram_rdata
);
	import cpu_pkg::*;

	logic [31:0] mem [2**DATA_ADDR_W];

	// Read returns the old word on a write cycle.
	always_ff @(posedge CLK) begin
		if (ram_we) mem[ram_addr] <= ram_wdata;
		ram_rdata <= mem[ram_addr];
	end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
	input  logic       CLK,
	input  logic       rst_n,
	input  logic       uart_rx_pin,
	output logic [7:0] rx_data,
	output logic       rx_req,
	input  logic       rx_ack
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e             state;
	logic [1:0]            sync;
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [2:0]            bit_idx;
	logic [7:0]            shift;
	logic                  line;
	logic                  mid_bit;
	logic                  bit_end;
	logic                  frame_ok;

	assign line     = sync[1];
	assign mid_bit  = baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);
	assign bit_end  = baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1);
	// Good stop bit and the previous byte fully handed over.
	assign frame_ok = state == RX_STOP && bit_end && line && !rx_req && !rx_ack;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			sync     <= 2'b11;  // Line idles high.
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			rx_req   <= 1'b0;
		end else begin
			sync <= {sync[0], uart_rx_pin};
			if (rx_req && rx_ack) rx_req <= 1'b0;
			if (frame_ok) rx_req <= 1'b1;
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!line) state <= RX_START;
				end
				RX_START: begin
					if (mid_bit) begin
						baud_cnt <= '0;  // Realign to mid-bit.
						bit_idx  <= '0;
						state    <= line ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (bit_end) state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == RX_DATA && bit_end) shift <= {line, shift[7:1]};  // LSB first.
		if (frame_ok) rx_data <= shift;
	end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
	input  logic       CLK,
	input  logic       rst_n,
	input  logic [7:0] tx_data,
	input  logic       tx_req,
	output logic       tx_ack,
	output logic       uart_tx_pin
);
	import cpu_pkg::*;

	typedef enum logic {
		TX_IDLE,
		TX_SHIFT
	} tx_state_e;

	tx_state_e             state;
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [3:0]            bit_idx;
	logic [9:0]            shift;
	logic                  bit_end;
	logic                  accept;

	assign bit_end     = baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1);
	assign accept      = state == TX_IDLE && tx_req && !tx_ack;
	assign uart_tx_pin = (state == TX_SHIFT) ? shift[0] : 1'b1;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			tx_ack   <= 1'b0;
		end else begin
			if (accept) begin
				state    <= TX_SHIFT;
				tx_ack   <= 1'b1;
				baud_cnt <= '0;
				bit_idx  <= '0;
			end else if (tx_ack && !tx_req) begin
				tx_ack <= 1'b0;
			end
			if (state == TX_SHIFT) begin
				baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
				if (bit_end) begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 4'd9) state <= TX_IDLE;  // Stop bit done.
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) shift <= {1'b1, tx_data, 1'b0};
		else if (state == TX_SHIFT && bit_end) shift <= {1'b1, shift[9:1]};
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary -f sources.f --top-module cpu_tb -o cpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status."
	exit $status
fi

./obj_dir/cpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status."
	exit $status
fi

exit 0

// File: sources.f
+incdir+include
design/cpu_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/data_ram.sv
design/cpu_core.sv
design/cpu_top.sv
test/cpu_tb.sv

// File: include/tb_uart_util.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random numbers and instruction encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

function automatic logic [31:0] enc_r(funct_e fn, int rs, int rt, int rd, int sh);
	return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic logic [31:0] enc_i(opcode_e op, int rs, int rt, int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] enc_j(opcode_e op, int target);
	return {op, 26'(target)};
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART line driver and monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic drive_bit(input logic v);
	@(posedge CLK);
	uart_rx_pin <= v;
	repeat (CLKS_PER_BIT - 1) @(posedge CLK);
endtask

task automatic send_byte(input logic [7:0] b);
	drive_bit(1'b0);
	for (int i = 0; i < 8; i++) drive_bit(b[i]);  // LSB first.
	repeat (3) drive_bit(1'b1);  // Stop bit and two idle bits.
endtask

task automatic watch_tx_line();
	logic [7:0] b;
	forever begin
		@(negedge uart_tx_pin);
		repeat (CLKS_PER_BIT / 2) @(negedge CLK);  // Middle of the start bit.
		if (uart_tx_pin !== 1'b0) fail_run("Start bit on uart_tx_pin was too short.");
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge CLK);
			b[i] = uart_tx_pin;
		end
		repeat (CLKS_PER_BIT) @(negedge CLK);
		if (uart_tx_pin !== 1'b1) fail_run("Bad stop bit on uart_tx_pin.");
		got_q.push_back(b);
	end
endtask

// File: test/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	typedef logic [7:0] byte_q_t[$];

	logic        CLK;
	logic        rst_n;
	logic        uart_rx_pin;
	logic        sw_load;
	logic        sw_run;
	logic        uart_tx_pin;
	logic        led_load;
	logic        led_run;
	logic [5:0]  debug_pc;

	logic [31:0] prog [256];
	int          plen;
	logic [31:0] lcg_state;
	byte_q_t     got_q;
	byte_q_t     exp_q;
	byte_q_t     stim_q;
	int          matched;
	longint      deadline;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			fail_run("Value mismatch.");
		end
	endtask

	`include "tb_uart_util.svh"

	cpu_top dut_i (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.uart_rx_pin(uart_rx_pin),
		.uart_tx_pin(uart_tx_pin),
		.sw_load    (sw_load),
		.sw_run     (sw_run),
		.led_load   (led_load),
		.led_run    (led_run),
		.debug_pc   (debug_pc)
	);

	always #10 CLK = ~CLK;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference interpreter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic void ref_run();
		logic [31:0] r [32];
		logic [31:0] m [256];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] ea;
		logic [7:0]  pcv;
		logic [7:0]  nxt;
		byte_q_t     ins;
		ins = stim_q;
		pcv = '0;
		for (int i = 0; i < 32; i++) r[i] = '0;
		for (int i = 0; i < 256; i++) m[i] = '0;
		for (int step = 0; step < 20000; step++) begin
			w   = prog[pcv];
			a   = r[w[25:21]];
			b   = r[w[20:16]];
			se  = {{16{w[15]}}, w[15:0]};
			ea  = a + se;
			nxt = pcv + 8'd1;
			if (w[31:26] == OP_J && w[7:0] == pcv) break;  // Program end.
			if (w[31:26] == OP_IN && ins.size() == 0) break;  // Waits for input forever.
			case (opcode_e'(w[31:26]))
				OP_SPECIAL: case (funct_e'(w[5:0]))
					FUNCT_ADD: r[w[15:11]] = a + b;
					FUNCT_SUB: r[w[15:11]] = a - b;
					FUNCT_AND: r[w[15:11]] = a & b;
					FUNCT_OR:  r[w[15:11]] = a | b;
					FUNCT_NOR: r[w[15:11]] = ~(a | b);
					FUNCT_SLL: r[w[15:11]] = b << w[10:6];
					FUNCT_SRL: r[w[15:11]] = b >> w[10:6];
					FUNCT_SLT: r[w[15:11]] = {31'b0, $signed(a) < $signed(b)};
					FUNCT_JR:  nxt = a[7:0];
					FUNCT_JALR: begin
						r[31] = {24'b0, nxt};
						nxt   = a[7:0];
					end
					default: ;
				endcase
				OP_ADDI: r[w[20:16]] = a + se;
				OP_ANDI: r[w[20:16]] = a & {16'b0, w[15:0]};
				OP_ORI:  r[w[20:16]] = a | {16'b0, w[15:0]};
				OP_SLTI: r[w[20:16]] = {31'b0, $signed(a) < $signed(se)};
				OP_LUI:  r[w[20:16]] = {w[15:0], 16'b0};
				OP_BEQ:  if (a == b) nxt = pcv + se[7:0];
				OP_BNE:  if (a != b) nxt = pcv + se[7:0];
				OP_J:    nxt = w[7:0];
				OP_JAL: begin
					r[31] = {24'b0, nxt};
					nxt   = w[7:0];
				end
				OP_LW:  r[w[20:16]] = m[ea[7:0]];
				OP_SW:  m[ea[7:0]] = b;
				OP_IN:  r[w[20:16]] = {b[31:8], ins.pop_front()};
				OP_OUT: exp_q.push_back(b[7:0]);
				default: ;
			endcase
			pcv = nxt;
		end
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Program builders
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic emit(input logic [31:0] w);
		prog[plen] = w;
		plen++;
	endtask

	task automatic load_imm(input int rd, input logic [31:0] v);
		emit(enc_i(OP_LUI, 0, rd, int'(v[31:16])));
		emit(enc_i(OP_ORI, rd, rd, int'(v[15:0])));
	endtask

	task automatic show(input int rd);  // Low byte, then bits 23:16.
		emit(enc_i(OP_OUT, 0, rd, 0));
		emit(enc_r(FUNCT_SRL, 0, rd, 4, 16));
		emit(enc_i(OP_OUT, 0, 4, 0));
	endtask

	task automatic build_alu();
		logic [31:0] a;
		logic [31:0] b;
		plen = 0;
		stim_q = {};
		a = lcg_next() & 32'h7fff_ffff;
		b = lcg_next() | 32'h8000_0000;  // Negative operand.
		load_imm(1, a);
		load_imm(2, b);
		emit(enc_r(FUNCT_ADD, 1, 2, 3, 0));
		show(3);
		emit(enc_r(FUNCT_SUB, 1, 2, 3, 0));
		show(3);
		emit(enc_r(FUNCT_AND, 1, 2, 3, 0));
		show(3);
		emit(enc_r(FUNCT_OR, 1, 2, 3, 0));
		show(3);
		emit(enc_r(FUNCT_NOR, 1, 2, 3, 0));
		show(3);
		emit(enc_r(FUNCT_SLT, 1, 2, 3, 0));
		show(3);
		emit(enc_r(FUNCT_SLT, 2, 1, 3, 0));
		show(3);
		emit(enc_r(FUNCT_SLL, 0, 2, 3, int'(lcg_next() >> 27)));
		show(3);
		emit(enc_r(FUNCT_SRL, 0, 2, 3, int'(lcg_next() >> 27)));
		show(3);
		emit(enc_i(OP_ADDI, 1, 3, int'(lcg_next() >> 16)));
		show(3);
		emit(enc_i(OP_ANDI, 2, 3, int'(lcg_next() >> 16)));
		show(3);
		emit(enc_i(OP_ORI, 1, 3, int'(lcg_next() >> 16)));
		show(3);
		emit(enc_i(OP_SLTI, 2, 3, -256));
		show(3);
		emit(enc_i(OP_SLTI, 1, 3, -1));
		show(3);
		emit(enc_i(OP_LUI, 0, 3, int'(lcg_next() >> 16)));
		show(3);
		emit(enc_j(OP_J, plen));
	endtask

	task automatic build_mem();
		plen = 0;
		stim_q = {};
		emit(enc_i(OP_LUI, 0, 0, 0));
		for (int i = 1; i <= 4; i++) load_imm(i, lcg_next());
		emit(enc_i(OP_SW, 0, 1, 3));
		emit(enc_i(OP_SW, 0, 2, -1));  // Wraps to word 255.
		emit(enc_i(OP_SW, 0, 3, 'h40));
		emit(enc_i(OP_SW, 0, 4, 'h80));
		emit(enc_i(OP_LW, 0, 6, 'h40));
		show(6);
		emit(enc_i(OP_LW, 0, 6, 3));
		show(6);
		emit(enc_i(OP_LW, 0, 6, 'h80));
		show(6);
		emit(enc_i(OP_LW, 0, 6, -1));
		show(6);
		emit(enc_j(OP_J, plen));
	endtask

	task automatic build_ctrl();
		int jal_at;
		int addr_at;
		plen = 0;
		stim_q = {};
		emit(enc_i(OP_LUI, 0, 0, 0));
		emit(enc_i(OP_LUI, 0, 5, 0));  // Subroutine counter.
		emit(enc_i(OP_ORI, 0, 1, 5));
		emit(enc_i(OP_ORI, 0, 2, 1));
		emit(enc_i(OP_OUT, 0, 1, 0));  // Countdown loop.
		emit(enc_r(FUNCT_SUB, 1, 2, 1, 0));
		emit(enc_i(OP_BNE, 1, 0, -2));
		emit(enc_i(OP_BEQ, 1, 2, 2));  // Not taken.
		emit(enc_i(OP_ORI, 0, 3, 'h55));
		emit(enc_i(OP_OUT, 0, 3, 0));
		jal_at = plen;
		emit(32'h0);
		emit(enc_i(OP_OUT, 0, 31, 0));
		addr_at = plen;
		emit(32'h0);
		emit(enc_r(FUNCT_JALR, 4, 0, 31, 0));
		emit(enc_i(OP_OUT, 0, 31, 0));
		emit(enc_j(OP_J, plen));
		prog[jal_at] = enc_j(OP_JAL, plen);  // Subroutine.
		prog[addr_at] = enc_i(OP_ORI, 0, 4, plen);
		emit(enc_i(OP_ADDI, 5, 5, 'h21));
		emit(enc_i(OP_OUT, 0, 5, 0));
		emit(enc_r(FUNCT_JR, 31, 0, 0, 0));
	endtask

	task automatic build_echo();
		plen = 0;
		stim_q = {};
		emit(enc_i(OP_LUI, 0, 2, 0));
		emit(enc_i(OP_IN, 0, 2, 0));
		emit(enc_i(OP_ADDI, 2, 2, 1));
		emit(enc_i(OP_OUT, 0, 2, 0));
		emit(enc_j(OP_J, 1));
		emit(enc_j(OP_J, plen));
		for (int i = 0; i < 12; i++) stim_q.push_back(8'(lcg_next() >> 24));
	endtask

	task automatic build_short();
		plen = 0;
		stim_q = {};
		load_imm(1, lcg_next());
		emit(enc_i(OP_OUT, 0, 1, 0));
		emit(enc_i(OP_ADDI, 1, 1, -3));
		emit(enc_i(OP_OUT, 0, 1, 0));
		emit(enc_j(OP_J, plen));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scenario control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic arm_watchdog(input int frames);
		deadline = $time + longint'(frames) * 12 * CLKS_PER_BIT * 20 + 20000;
	endtask

	task automatic load_words(input int n);
		for (int w = 0; w < n; w++) begin
			for (int k = 0; k < 4; k++) send_byte(prog[w][8*k +: 8]);  // Little-endian.
		end
	endtask

	task automatic pulse_load();
		@(posedge CLK);
		sw_load <= 1'b1;
		@(posedge CLK);
		sw_load <= 1'b0;
		@(negedge CLK);
		check_value("led_load", 32'(led_load), 32'd1);
		check_value("led_run", 32'(led_run), 32'd0);
		check_value("debug_pc", 32'(debug_pc), 32'd0);
	endtask

	task automatic run_program();
		int n_exp;
		ref_run();
		n_exp = exp_q.size();
		matched = 0;
		arm_watchdog(plen * 4 + stim_q.size() + n_exp);
		load_words(plen);
		@(posedge CLK);
		sw_run <= 1'b1;
		@(posedge CLK);
		sw_run <= 1'b0;
		@(negedge CLK);
		check_value("led_run", 32'(led_run), 32'd1);
		foreach (stim_q[i]) send_byte(stim_q[i]);
		while (matched < n_exp) @(negedge CLK);
		repeat (24 * CLKS_PER_BIT) @(posedge CLK);  // Room for stray output.
		pulse_load();
	endtask

	initial begin
		@(posedge rst_n);
		watch_tx_line();
	end

	initial begin
		forever begin
			@(negedge CLK);
			if (got_q.size() > 0) begin
				if (led_load) fail_run("UART output appeared in load mode.");
				if (exp_q.size() == 0) fail_run("The DUT sent more bytes than expected.");
				check_value("uart_tx_pin byte", 32'(got_q.pop_front()), 32'(exp_q.pop_front()));
				matched++;
			end
		end
	end

	initial begin
		forever begin
			@(negedge CLK);
			if ($time > deadline) fail_run("Timeout: the DUT did not send all expected bytes.");
		end
	end

	initial begin
		CLK         = 1'b0;
		rst_n       = 1'b0;
		uart_rx_pin = 1'b1;
		sw_load     = 1'b0;
		sw_run      = 1'b0;
		lcg_state   = 32'd46;
		plen        = 0;
		matched     = 0;
		deadline    = 64'd100000;
		repeat (5) @(posedge CLK);
		rst_n <= 1'b1;
		@(negedge CLK);
		check_value("led_load", 32'(led_load), 32'd1);
		check_value("led_run", 32'(led_run), 32'd0);
		check_value("debug_pc", 32'(debug_pc), 32'd0);

		build_alu();
		arm_watchdog(9);
		load_words(2);
		@(negedge CLK);
		check_value("debug_pc", 32'(debug_pc), 32'h08);  // Word 2, byte 0.
		send_byte(prog[2][7:0]);
		@(negedge CLK);
		check_value("debug_pc", 32'(debug_pc), 32'h09);  // Word 2, byte 1.
		pulse_load();
		run_program();

		build_mem();
		run_program();
		build_ctrl();
		run_program();
		build_echo();
		run_program();
		build_short();  // Reload after an endless echo loop.
		run_program();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
